/* rtl/l2_params.svh */
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// Byte address width of both the upper and the memory side.
`define L2_ADDR_W 16

// One line is eight bytes.
`define L2_LINE_W 64
`define L2_OFFSET_W 3

// Eight sets.
`define L2_SET_W 3

`define L2_CNT_W 16

`endif

/* rtl/l2_pkg.sv */
`default_nettype none

`include "l2_params.svh"

package l2_pkg;

	typedef logic [`L2_ADDR_W-1:0] addr_t;
	typedef logic [`L2_LINE_W-1:0] line_t;
	typedef logic [`L2_SET_W-1:0] set_t;

	// The tag is whatever is left above the set index and byte offset.
	typedef logic [`L2_ADDR_W-`L2_SET_W-`L2_OFFSET_W-1:0] tag_t;

	typedef logic [1:0] way_t;

	// Age 0 is the most recently used way, age 3 the least.
	typedef logic [1:0] age_t;

	typedef logic [3:0] way_vec_t;
	typedef logic [`L2_CNT_W-1:0] cnt_t;

	typedef enum logic [1:0] {
		st_ready,
		st_fetch,
		st_write_back
	} l2_state_e;

	// A dirty victim waiting to be written back to memory.
	typedef struct packed {
		addr_t addr;
		line_t line;
	} evict_entry_t;

endpackage

`default_nettype wire

/* rtl/l2_way_if.sv */
`default_nettype none

interface l2_way_if (
	input logic clk,
	input logic reset_l2hits
);
	import l2_pkg::*;

	// Status of the addressed set, from the datapath.
	logic hit;
	way_t hit_way;
	way_vec_t valid;
	way_vec_t dirty;
	age_t [3:0] age;

	// Write strobes and selects, from the control.
	way_vec_t data_we;
	way_vec_t tag_we;
	way_vec_t valid_we;
	way_vec_t dirty_we;
	logic dirty_val;
	logic fill_sel;
	logic age_touch;
	way_t touch_way;

	modport dp (
		input clk, reset_l2hits,
		output hit, hit_way, valid, dirty, age,
		input data_we, tag_we, valid_we, dirty_we, dirty_val, fill_sel, age_touch, touch_way
	);

	modport ctrl (
		input clk, reset_l2hits,
		input hit, hit_way, valid, dirty, age,
		output data_we, tag_we, valid_we, dirty_we, dirty_val, fill_sel, age_touch, touch_way
	);

endinterface

`default_nettype wire

/* rtl/l2_control.sv */
`default_nettype none

module l2_control (
	input logic clk,
	input logic reset_l2hits,
	input logic pmem_read,
	input logic pmem_write,
	input logic physical_resp,
	input logic ewb_empty,
	l2_way_if.ctrl ways,
	output logic pmem_resp,
	output logic physical_read,
	output logic physical_write,
	output logic load_ewb,
	output logic addr_sel,
	output l2_pkg::cnt_t hit_count,
	output l2_pkg::cnt_t miss_count
);
	import l2_pkg::*;

	localparam int WAYS = $bits(way_vec_t);

	l2_state_e state;
	l2_state_e next_state;
	logic request;
	way_t victim;
	logic victim_dirty;
	logic fill_done;
	logic miss_pending;

	assign request = pmem_read | pmem_write;

	// An invalid way is always preferred. Otherwise the oldest way goes.
	always_comb begin
		victim = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (ways.age[w] == 2'd3)
				victim = way_t'(w);
		end
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!ways.valid[w])
				victim = way_t'(w);
		end
	end

	assign victim_dirty = ways.valid[victim] & ways.dirty[victim];
	assign fill_done = (state == st_fetch) & physical_read & physical_resp;

	always_ff @(posedge clk or posedge reset_l2hits) begin
		if (reset_l2hits)
			state <= st_ready;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		pmem_resp = 1'b0;
		physical_read = 1'b0;
		physical_write = 1'b0;
		load_ewb = 1'b0;
		addr_sel = 1'b0;
		ways.data_we = '0;
		ways.tag_we = '0;
		ways.valid_we = '0;
		ways.dirty_we = '0;
		ways.dirty_val = 1'b0;
		ways.fill_sel = 1'b0;
		ways.age_touch = 1'b0;
		ways.touch_way = ways.hit_way;

		case (state)
			st_ready: begin
				if (request && ways.hit) begin
					pmem_resp = 1'b1;
					ways.age_touch = 1'b1;
					if (pmem_write) begin
						ways.data_we[ways.hit_way] = 1'b1;
						ways.dirty_we[ways.hit_way] = 1'b1;
						ways.dirty_val = 1'b1;
					end
				end else if (request) begin
					next_state = st_fetch;
				end
			end
			st_fetch: begin
				if (victim_dirty) begin
					// The victim moves to the buffer and is clean from here on.
					if (ewb_empty) begin
						load_ewb = 1'b1;
						ways.dirty_we[victim] = 1'b1;
						next_state = st_write_back;
					end
				end else begin
					physical_read = 1'b1;
					ways.fill_sel = 1'b1;
					if (physical_resp) begin
						ways.data_we[victim] = 1'b1;
						ways.tag_we[victim] = 1'b1;
						ways.valid_we[victim] = 1'b1;
						ways.dirty_we[victim] = 1'b1;
						ways.age_touch = 1'b1;
						ways.touch_way = victim;
						next_state = st_ready;
					end
				end
			end
			st_write_back: begin
				physical_write = 1'b1;
				addr_sel = 1'b1;
				if (physical_resp)
					next_state = st_fetch;
			end
			default: begin
				next_state = st_ready;
			end
		endcase
	end

	// A request that missed is answered once the fill is done, and that answer is no hit.
	always_ff @(posedge clk or posedge reset_l2hits) begin
		if (reset_l2hits) begin
			miss_pending <= 1'b0;
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			if (state == st_ready && next_state == st_fetch)
				miss_pending <= 1'b1;
			else if (pmem_resp)
				miss_pending <= 1'b0;
			if (pmem_resp && !miss_pending)
				hit_count <= hit_count + cnt_t'(1);
			if (fill_done)
				miss_count <= miss_count + cnt_t'(1);
		end
	end

endmodule

`default_nettype wire

/* rtl/l2_datapath.sv */
`default_nettype none

`include "l2_params.svh"

module l2_datapath (
	input logic clk,
	input logic reset_l2hits,
	input l2_pkg::addr_t address,
	input l2_pkg::line_t wdata,
	input l2_pkg::line_t fill_data,
	l2_way_if.dp ways,
	output l2_pkg::line_t rdata,
	output l2_pkg::evict_entry_t victim_entry
);
	import l2_pkg::*;

	localparam int WAYS = $bits(way_vec_t);
	localparam int SETS = 2 ** `L2_SET_W;

	tag_t tag_arr [WAYS][SETS];
	line_t data_arr [WAYS][SETS];
	logic valid_arr [WAYS][SETS];
	logic dirty_arr [WAYS][SETS];
	age_t age_arr [WAYS][SETS];

	set_t set;
	tag_t tag;
	way_vec_t hit_vec;
	way_t oldest;
	line_t wr_line;

	assign set = address[`L2_OFFSET_W +: `L2_SET_W];
	assign tag = address[`L2_ADDR_W-1 -: $bits(tag_t)];

	assign wr_line = ways.fill_sel ? fill_data : wdata;

	always_comb begin
		ways.hit_way = '0;
		oldest = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit_vec[w] = valid_arr[w][set] && (tag_arr[w][set] == tag);
			ways.valid[w] = valid_arr[w][set];
			ways.dirty[w] = dirty_arr[w][set];
			ways.age[w] = age_arr[w][set];
			if (hit_vec[w])
				ways.hit_way = way_t'(w);
			if (age_arr[w][set] == 2'd3)
				oldest = way_t'(w);
		end
	end

	assign ways.hit = |hit_vec;
	assign rdata = data_arr[ways.hit_way][set];

	// The line address is rebuilt from the stored tag of the oldest way.
	assign victim_entry.addr = {tag_arr[oldest][set], set, {`L2_OFFSET_W{1'b0}}};
	assign victim_entry.line = data_arr[oldest][set];

	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (ways.data_we[w])
				data_arr[w][set] <= wr_line;
			if (ways.tag_we[w])
				tag_arr[w][set] <= tag;
		end
	end

	// Ages start out equal to the way number so each set holds a full ordering.
	always_ff @(posedge clk or posedge reset_l2hits) begin
		if (reset_l2hits) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					valid_arr[w][s] <= 1'b0;
					dirty_arr[w][s] <= 1'b0;
					age_arr[w][s] <= age_t'(w);
				end
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (ways.valid_we[w])
					valid_arr[w][set] <= 1'b1;
				if (ways.dirty_we[w])
					dirty_arr[w][set] <= ways.dirty_val;
			end
			if (ways.age_touch) begin
				for (int w = 0; w < WAYS; w++) begin
					if (way_t'(w) == ways.touch_way)
						age_arr[w][set] <= '0;
					else if (age_arr[w][set] < age_arr[ways.touch_way][set])
						age_arr[w][set] <= age_arr[w][set] + age_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/l2_evict_buffer.sv */
`default_nettype none

module l2_evict_buffer (
	input logic clk,
	input logic reset_l2hits,
	input logic load_ewb,
	input logic physical_resp,
	input logic physical_write,
	input l2_pkg::evict_entry_t entry_in,
	output logic ewb_empty,
	output l2_pkg::evict_entry_t entry_out
);
	import l2_pkg::*;

	logic full;
	evict_entry_t entry;

	// The buffer stays busy until memory acknowledges the write of its line.
	always_ff @(posedge clk or posedge reset_l2hits) begin
		if (reset_l2hits)
			full <= 1'b0;
		else if (load_ewb)
			full <= 1'b1;
		else if (physical_write && physical_resp)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load_ewb)
			entry <= entry_in;
	end

	assign ewb_empty = ~full;
	assign entry_out = entry;

endmodule

`default_nettype wire

/* rtl/l2_cache.sv */
`default_nettype none

`include "l2_params.svh"

module l2_cache (
	input logic clk,
	input logic reset_l2hits,
	input logic pmem_read,
	input logic pmem_write,
	input l2_pkg::addr_t pmem_address,
	input l2_pkg::line_t pmem_wdata,
	output logic pmem_resp,
	output l2_pkg::line_t pmem_rdata,
	output logic physical_read,
	output logic physical_write,
	output l2_pkg::addr_t physical_address,
	output l2_pkg::line_t physical_wdata,
	input logic physical_resp,
	input l2_pkg::line_t physical_rdata,
	output l2_pkg::cnt_t hit_count,
	output l2_pkg::cnt_t miss_count
);
	import l2_pkg::*;

	logic ewb_empty;
	logic load_ewb;
	logic addr_sel;
	evict_entry_t victim_entry;
	evict_entry_t ewb_entry;
	addr_t line_address;

	l2_way_if ways (
		.clk(clk),
		.reset_l2hits(reset_l2hits)
	);

	l2_control u_control (
		.clk(clk),
		.reset_l2hits(reset_l2hits),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.physical_resp(physical_resp),
		.ewb_empty(ewb_empty),
		.ways(ways.ctrl),
		.pmem_resp(pmem_resp),
		.physical_read(physical_read),
		.physical_write(physical_write),
		.load_ewb(load_ewb),
		.addr_sel(addr_sel),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

	l2_datapath u_datapath (
		.clk(clk),
		.reset_l2hits(reset_l2hits),
		.address(pmem_address),
		.wdata(pmem_wdata),
		.fill_data(physical_rdata),
		.ways(ways.dp),
		.rdata(pmem_rdata),
		.victim_entry(victim_entry)
	);

	l2_evict_buffer u_evict (
		.clk(clk),
		.reset_l2hits(reset_l2hits),
		.load_ewb(load_ewb),
		.physical_resp(physical_resp),
		.physical_write(physical_write),
		.entry_in(victim_entry),
		.ewb_empty(ewb_empty),
		.entry_out(ewb_entry)
	);

	// Memory always sees whole lines, so the byte offset is dropped.
	assign line_address = {pmem_address[`L2_ADDR_W-1:`L2_OFFSET_W], {`L2_OFFSET_W{1'b0}}};
	assign physical_address = addr_sel ? ewb_entry.addr : line_address;
	assign physical_wdata = ewb_entry.line;

endmodule

`default_nettype wire

/* test/l2_mem_model.sv */
`default_nettype none

`include "l2_params.svh"

module l2_mem_model (
	input logic clk,
	input logic reset_l2hits,
	input logic read,
	input logic write,
	input l2_pkg::addr_t address,
	input l2_pkg::line_t wdata,
	output logic resp,
	output l2_pkg::line_t rdata
);
	import l2_pkg::*;

	localparam int LINES = 2 ** (`L2_ADDR_W - `L2_OFFSET_W);

	line_t mem [LINES];
	int count;

	// Every line starts with a pattern built from its full line index.
	initial begin
		for (int i = 0; i < LINES; i++)
			mem[i] = {16'(i), ~16'(i), 16'hc0de ^ 16'(i), 16'h5a00 + 16'(i)};
	end

	// Each request is answered on the third edge after it appears.
	always @(posedge clk or posedge reset_l2hits) begin
		if (reset_l2hits) begin
			resp <= 1'b0;
			count <= 0;
			rdata <= '0;
		end else if (resp) begin
			resp <= 1'b0;
			count <= 0;
		end else if (read || write) begin
			if (count == 2) begin
				resp <= 1'b1;
				rdata <= mem[address[`L2_ADDR_W-1:`L2_OFFSET_W]];
				if (write)
					mem[address[`L2_ADDR_W-1:`L2_OFFSET_W]] <= wdata;
			end else begin
				count <= count + 1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/l2_cache_tb.sv */
`default_nettype none

`include "l2_params.svh"

module l2_cache_tb;
	import l2_pkg::*;

	// The longest miss takes about a dozen cycles, so 320 accesses fit well inside this.
	localparam int MAX_CYCLES = 20000;
	localparam int LINES = 2 ** (`L2_ADDR_W - `L2_OFFSET_W);

	logic clk;
	logic reset_l2hits;
	logic pmem_read;
	logic pmem_write;
	addr_t pmem_address;
	line_t pmem_wdata;
	logic pmem_resp;
	line_t pmem_rdata;
	logic physical_read;
	logic physical_write;
	addr_t physical_address;
	line_t physical_wdata;
	logic physical_resp;
	line_t physical_rdata;
	cnt_t hit_count;
	cnt_t miss_count;

	// Reference copy of the cache and of memory.
	tag_t ref_tag [4][8];
	logic ref_valid [4][8];
	logic ref_dirty [4][8];
	age_t ref_age [4][8];
	line_t ref_line [4][8];
	line_t ref_mem [LINES];

	int req_count;
	int resp_count;
	int wb_exp_count;
	int wb_seen_count;
	int cycle_count;
	int exp_hits;
	int exp_misses;
	logic exp_is_read;
	line_t exp_rdata;
	addr_t exp_wb_addr;
	line_t exp_wb_data;
	integer seed;

	l2_cache u_dut (
		.clk(clk),
		.reset_l2hits(reset_l2hits),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata),
		.physical_read(physical_read),
		.physical_write(physical_write),
		.physical_address(physical_address),
		.physical_wdata(physical_wdata),
		.physical_resp(physical_resp),
		.physical_rdata(physical_rdata),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

	l2_mem_model u_mem (
		.clk(clk),
		.reset_l2hits(reset_l2hits),
		.read(physical_read),
		.write(physical_write),
		.address(physical_address),
		.wdata(physical_wdata),
		.resp(physical_resp),
		.rdata(physical_rdata)
	);

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	function automatic line_t initial_line(input int idx);
		return {16'(idx), ~16'(idx), 16'hc0de ^ 16'(idx), 16'h5a00 + 16'(idx)};
	endfunction

	function automatic void touch_age(input set_t s, input int way);
		age_t old;
		old = ref_age[way][s];
		for (int w = 0; w < 4; w++) begin
			if (w == way)
				ref_age[w][s] = '0;
			else if (ref_age[w][s] < old)
				ref_age[w][s] = ref_age[w][s] + age_t'(1);
		end
	endfunction

	// Returns the line as it stood before the access; a write updates the copy afterwards.
	function automatic line_t model_access(input logic wr, input addr_t addr, input line_t wdata,
			output logic hit, output logic wb, output addr_t wb_addr, output line_t wb_data);
		set_t s;
		tag_t t;
		int way;
		int victim;
		line_t result;
		s = addr[`L2_OFFSET_W +: `L2_SET_W];
		t = addr[`L2_ADDR_W-1 -: $bits(tag_t)];
		hit = 1'b0;
		wb = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		way = 0;
		for (int w = 0; w < 4; w++) begin
			if (ref_valid[w][s] && ref_tag[w][s] == t) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			victim = -1;
			for (int w = 3; w >= 0; w--) begin
				if (!ref_valid[w][s])
					victim = w;
			end
			if (victim < 0) begin
				for (int w = 0; w < 4; w++) begin
					if (ref_age[w][s] == 2'd3)
						victim = w;
				end
			end
			if (ref_valid[victim][s] && ref_dirty[victim][s]) begin
				wb = 1'b1;
				wb_addr = {ref_tag[victim][s], s, {`L2_OFFSET_W{1'b0}}};
				wb_data = ref_line[victim][s];
				ref_mem[wb_addr[`L2_ADDR_W-1:`L2_OFFSET_W]] = wb_data;
			end
			ref_line[victim][s] = ref_mem[addr[`L2_ADDR_W-1:`L2_OFFSET_W]];
			ref_tag[victim][s] = t;
			ref_valid[victim][s] = 1'b1;
			ref_dirty[victim][s] = 1'b0;
			way = victim;
		end
		touch_age(s, way);
		result = ref_line[way][s];
		if (wr) begin
			ref_line[way][s] = wdata;
			ref_dirty[way][s] = 1'b1;
		end
		return result;
	endfunction

	// Called on a falling edge; returns on the falling edge after the response.
	task automatic do_access(input logic wr, input addr_t addr, input line_t wdata);
		logic hit;
		logic wb;
		addr_t wb_addr;
		line_t wb_data;
		int cycles;
		exp_rdata = model_access(wr, addr, wdata, hit, wb, wb_addr, wb_data);
		exp_is_read = !wr;
		if (wb) begin
			exp_wb_addr = wb_addr;
			exp_wb_data = wb_data;
			wb_exp_count++;
		end
		pmem_read = !wr;
		pmem_write = wr;
		pmem_address = addr;
		pmem_wdata = wdata;
		req_count++;
		cycles = 0;
		while (resp_count != req_count) begin
			@(negedge clk);
			cycles++;
		end
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		if (hit && cycles != 1)
			stop_with_failure($sformatf("Access to %h should hit but took %0d cycles",
				addr, cycles));
		if (!hit && cycles == 1)
			stop_with_failure($sformatf("Access to %h should miss but hit", addr));
		if (wb_seen_count != wb_exp_count)
			stop_with_failure($sformatf("Write-back count is %0d but %0d were expected",
				wb_seen_count, wb_exp_count));
		if (hit)
			exp_hits++;
		else
			exp_misses++;
		check_cnt("hit_count", hit_count, cnt_t'(exp_hits));
		check_cnt("miss_count", miss_count, cnt_t'(exp_misses));
	endtask

	always @(posedge clk) begin
		if (!reset_l2hits) begin
			if (pmem_resp) begin
				if (resp_count == req_count)
					stop_with_failure("The cache answered with no request open.");
				if (exp_is_read)
					check_line("pmem_rdata", pmem_rdata, exp_rdata);
				resp_count++;
			end
			if (physical_write && physical_resp) begin
				if (wb_seen_count == wb_exp_count)
					stop_with_failure("The cache wrote a line back that should stay cached.");
				check_addr("physical_address", physical_address, exp_wb_addr);
				check_line("physical_wdata", physical_wdata, exp_wb_data);
				wb_seen_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
			stop_with_failure("Timeout: the run did not finish in the cycle limit.");
	end

	initial begin
		clk = 1'b0;
		reset_l2hits = 1'b1;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_address = '0;
		pmem_wdata = '0;
		seed = 82;
		req_count = 0;
		resp_count = 0;
		wb_exp_count = 0;
		wb_seen_count = 0;
		cycle_count = 0;
		exp_hits = 0;
		exp_misses = 0;
		exp_is_read = 1'b0;
		exp_rdata = '0;
		exp_wb_addr = '0;
		exp_wb_data = '0;
		for (int w = 0; w < 4; w++) begin
			for (int s = 0; s < 8; s++) begin
				ref_tag[w][s] = '0;
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
				ref_age[w][s] = age_t'(w);
				ref_line[w][s] = '0;
			end
		end
		for (int i = 0; i < LINES; i++)
			ref_mem[i] = initial_line(i);

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_l2hits = 1'b0;

		if (physical_read !== 1'b0 || physical_write !== 1'b0)
			stop_with_failure($sformatf("FAILED physical_read/physical_write got %h/%h expected 0/0",
				physical_read, physical_write));
		check_cnt("hit_count", hit_count, '0);
		check_cnt("miss_count", miss_count, '0);

		// Read miss, then a hit on the same line, then a write hit read back.
		do_access(1'b0, 16'h1238, '0);
		do_access(1'b0, 16'h123c, '0);
		do_access(1'b1, 16'h1238, 64'hdead_beef_0123_4567);
		do_access(1'b0, 16'h1238, '0);

		// Five tags in set 2 with a re-touch in between.
		for (int t = 1; t <= 4; t++)
			do_access(1'b0, {10'(t), 3'd2, 3'd0}, '0);
		do_access(1'b0, {10'd1, 3'd2, 3'd0}, '0);
		do_access(1'b0, {10'd5, 3'd2, 3'd0}, '0);
		do_access(1'b0, {10'd2, 3'd2, 3'd0}, '0);
		do_access(1'b0, {10'd1, 3'd2, 3'd0}, '0);

		// A dirty line in set 4 is pushed out by four newer tags.
		do_access(1'b1, {10'd10, 3'd4, 3'd0}, 64'h0f1e_2d3c_4b5a_6978);
		for (int t = 11; t <= 14; t++)
			do_access(1'b0, {10'(t), 3'd4, 3'd0}, '0);
		if (wb_seen_count != 1)
			stop_with_failure("The dirty line in set 4 was not written back.");
		check_line("memory line", u_mem.mem[exp_wb_addr[`L2_ADDR_W-1:`L2_OFFSET_W]],
			64'h0f1e_2d3c_4b5a_6978);

		for (int i = 0; i < 300; i++) begin
			int idx;
			idx = ($random(seed) & 32'h7fff_ffff) % 48;
			do_access(1'($random(seed)),
				{10'(idx / 8 + 20), 3'(idx % 8), 3'($random(seed))},
				{32'($random(seed)), 32'($random(seed))});
		end
		check_cnt("hit_count", hit_count, cnt_t'(exp_hits));
		check_cnt("miss_count", miss_count, cnt_t'(exp_misses));

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* l2_cache.f */
+incdir+rtl
rtl/l2_pkg.sv
rtl/l2_way_if.sv
rtl/l2_control.sv
rtl/l2_datapath.sv
rtl/l2_evict_buffer.sv
rtl/l2_cache.sv
test/l2_mem_model.sv
test/l2_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f l2_cache.f --top-module l2_cache_tb -o l2_sim

out=$(./obj_dir/l2_sim 2>&1) || true
echo "$out"

echo "$out" | grep -q "Simulation PASSED"
